// ==== logic/rob_pkg.sv ====
package rob_pkg;

    // dispatch, result bus and retire all run this wide
    localparam int lanes = 3;

    localparam int phys_tag_width = 6;
    localparam int arch_reg_width = 5;
    localparam int addr_width     = 32;

    // physical register tag, 64 registers
    typedef logic [phys_tag_width-1:0] phys_tag_t;

    // architectural register index
    typedef logic [arch_reg_width-1:0] arch_reg_t;

    // branch target address
    typedef logic [addr_width-1:0] addr_t;

    // circular buffer step, base plus a small offset wrapped at depth
    // step never exceeds the depth, so one subtraction is enough
    function automatic int unsigned wrap_index(
        input int unsigned base,
        input int unsigned step,
        input int unsigned depth
    );
        int unsigned sum;

        sum = base + step;
        if (sum >= depth) begin
            sum = sum - depth;
        end
        return sum;
    endfunction

endpackage

// ==== logic/rob_control.sv ====
`timescale 1ns/1ns

module rob_control import rob_pkg::*; #(
    parameter  int rob_depth   = 8,
    localparam int index_width = $clog2(rob_depth),
    localparam int count_width = $clog2(rob_depth + 1)
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic [lanes-1:0]       dispatch_valid,
    input  logic [1:0]             retire_count,
    input  logic                   flush,
    output logic [lanes-1:0]       dispatch_accept,
    output logic [index_width-1:0] alloc_index [lanes],
    output logic [count_width-1:0] open_spots,
    output logic [index_width-1:0] head
);

    logic [index_width-1:0] tail;
    logic [count_width-1:0] occupancy;

    logic [1:0]             accept_count;
    logic [index_width-1:0] next_head;
    logic [index_width-1:0] next_tail;
    logic [count_width-1:0] next_occupancy;

    // free entries once this cycle's retirements have left
    // a retiring misprediction empties the whole buffer
    always_comb begin
        if (flush) begin
            open_spots = count_width'(rob_depth);
        end else begin
            open_spots = count_width'(rob_depth) - occupancy + count_width'(retire_count);
        end
    end

    // each lane stands on its own valid, but lane k needs k+1 free slots
    always_comb begin
        for (int k = 0; k < lanes; k++) begin
            dispatch_accept[k] = dispatch_valid[k] && !flush &&
                                 (open_spots >= count_width'(k + 1));
        end
    end

    // accepted lanes take consecutive slots from the tail in lane order
    always_comb begin
        accept_count = 2'd0;
        for (int k = 0; k < lanes; k++) begin
            alloc_index[k] = index_width'(wrap_index(tail, accept_count, rob_depth));
            if (dispatch_accept[k]) begin
                accept_count = accept_count + 2'd1;
            end
        end
    end

    always_comb begin
        next_head      = index_width'(wrap_index(head, retire_count, rob_depth));
        next_tail      = index_width'(wrap_index(tail, accept_count, rob_depth));
        next_occupancy = occupancy - count_width'(retire_count) + count_width'(accept_count);
    end

    // flush restarts the buffer at entry 0
    always_ff @(posedge clock) begin
        if (reset || flush) begin
            head      <= '0;
            tail      <= '0;
            occupancy <= '0;
        end else begin
            head      <= next_head;
            tail      <= next_tail;
            occupancy <= next_occupancy;
        end
    end

    // retire window and acceptance together must keep the count in bounds
    occupancy_in_range: assert property (
        @(posedge clock) disable iff (reset)
        occupancy <= count_width'(rob_depth)
    );

endmodule

// ==== logic/rob_entry_table.sv ====
`timescale 1ns/1ns

module rob_entry_table import rob_pkg::*; #(
    parameter  int rob_depth   = 8,
    localparam int index_width = $clog2(rob_depth)
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic [lanes-1:0]       dispatch_accept,
    input  logic [index_width-1:0] alloc_index [lanes],
    input  phys_tag_t              dispatch_dest [lanes],
    input  phys_tag_t              dispatch_old [lanes],
    input  arch_reg_t              dispatch_arch [lanes],
    input  logic [lanes-1:0]       dispatch_predicted_taken,
    output phys_tag_t              entry_dest [rob_depth],
    output phys_tag_t              entry_old [rob_depth],
    output arch_reg_t              entry_arch [rob_depth],
    output logic [rob_depth-1:0]   entry_predicted_taken
);

    // static fields of an instruction, written once at allocation
    // and held until the slot comes round again
    always_ff @(posedge clock) begin
        for (int k = 0; k < lanes; k++) begin
            if (dispatch_accept[k]) begin
                entry_dest[alloc_index[k]]            <= dispatch_dest[k];
                entry_old[alloc_index[k]]             <= dispatch_old[k];
                entry_arch[alloc_index[k]]            <= dispatch_arch[k];
                entry_predicted_taken[alloc_index[k]] <= dispatch_predicted_taken[k];
            end
        end
    end

    // control must hand out distinct slots within one cycle
    for (genvar a = 0; a < lanes; a++) begin : g_lane_a
        for (genvar b = a + 1; b < lanes; b++) begin : g_lane_b
            distinct_alloc: assert property (
                @(posedge clock) disable iff (reset)
                !(dispatch_accept[a] && dispatch_accept[b] &&
                  alloc_index[a] == alloc_index[b])
            );
        end
    end

endmodule

// ==== logic/rob_status_table.sv ====
`timescale 1ns/1ns

module rob_status_table import rob_pkg::*; #(
    parameter  int rob_depth   = 8,
    localparam int index_width = $clog2(rob_depth)
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   flush,
    input  logic [lanes-1:0]       dispatch_accept,
    input  logic [index_width-1:0] alloc_index [lanes],
    input  logic [rob_depth-1:0]   release_mask,
    input  phys_tag_t              entry_dest [rob_depth],
    input  logic [rob_depth-1:0]   entry_predicted_taken,
    input  logic [lanes-1:0]       cdb_valid,
    input  phys_tag_t              cdb_tag [lanes],
    input  logic                   branch_valid,
    input  logic                   branch_taken,
    input  phys_tag_t              branch_tag,
    input  addr_t                  branch_target,
    output logic [rob_depth-1:0]   entry_valid,
    output logic [rob_depth-1:0]   entry_done,
    output logic [rob_depth-1:0]   entry_mispredict,
    output addr_t                  entry_target [rob_depth]
);

    logic [rob_depth-1:0] result_hit;
    logic [rob_depth-1:0] branch_hit;
    logic [rob_depth-1:0] redirect;

    // tag compare of every live entry against all three result buses
    // and the branch unit
    always_comb begin
        for (int i = 0; i < rob_depth; i++) begin
            result_hit[i] = 1'b0;
            for (int k = 0; k < lanes; k++) begin
                if (cdb_valid[k] && cdb_tag[k] == entry_dest[i]) begin
                    result_hit[i] = 1'b1;
                end
            end
            branch_hit[i] = entry_valid[i] && branch_valid && branch_tag == entry_dest[i];
            redirect[i]   = branch_hit[i] && (branch_taken != entry_predicted_taken[i]);
        end
    end

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            entry_valid      <= '0;
            entry_done       <= '0;
            entry_mispredict <= '0;
        end else begin
            for (int i = 0; i < rob_depth; i++) begin
                if (entry_valid[i] && (result_hit[i] || branch_hit[i])) begin
                    entry_done[i] <= 1'b1;
                end
                if (redirect[i]) begin
                    entry_mispredict[i] <= 1'b1;
                end
                if (release_mask[i]) begin
                    entry_valid[i] <= 1'b0;
                end
            end
            // allocation comes last, a slot retired and refilled
            // in the same cycle starts clean
            for (int k = 0; k < lanes; k++) begin
                if (dispatch_accept[k]) begin
                    entry_valid[alloc_index[k]]      <= 1'b1;
                    entry_done[alloc_index[k]]       <= 1'b0;
                    entry_mispredict[alloc_index[k]] <= 1'b0;
                end
            end
        end
    end

    // corrected target, only meaningful while mispredict is set
    always_ff @(posedge clock) begin
        for (int i = 0; i < rob_depth; i++) begin
            if (redirect[i]) begin
                entry_target[i] <= branch_target;
            end
        end
    end

endmodule

// ==== logic/rob_retire_window.sv ====
`timescale 1ns/1ns

module rob_retire_window import rob_pkg::*; #(
    parameter  int rob_depth   = 8,
    localparam int index_width = $clog2(rob_depth)
) (
    input  logic [index_width-1:0] head,
    input  logic [rob_depth-1:0]   entry_valid,
    input  logic [rob_depth-1:0]   entry_done,
    input  logic [rob_depth-1:0]   entry_mispredict,
    input  addr_t                  entry_target [rob_depth],
    input  arch_reg_t              entry_arch [rob_depth],
    input  phys_tag_t              entry_dest [rob_depth],
    input  phys_tag_t              entry_old [rob_depth],
    output logic [lanes-1:0]       retire_valid,
    output arch_reg_t              retire_arch [lanes],
    output phys_tag_t              retire_dest [lanes],
    output phys_tag_t              retire_old [lanes],
    output logic [rob_depth-1:0]   release_mask,
    output logic [1:0]             retire_count,
    output logic                   flush,
    output addr_t                  flush_target
);

    // walk head, head+1, head+2 in order
    // stop at the first unfinished entry or right after a mispredicted one
    always_comb begin
        logic                   stop;
        logic [index_width-1:0] slot;

        stop         = 1'b0;
        retire_valid = '0;
        release_mask = '0;
        retire_count = 2'd0;
        flush        = 1'b0;
        flush_target = '0;
        for (int k = 0; k < lanes; k++) begin
            slot           = index_width'(wrap_index(head, k, rob_depth));
            retire_arch[k] = '0;
            retire_dest[k] = '0;
            retire_old[k]  = '0;
            if (!stop && entry_valid[slot] && entry_done[slot]) begin
                retire_valid[k]    = 1'b1;
                retire_arch[k]     = entry_arch[slot];
                retire_dest[k]     = entry_dest[slot];
                retire_old[k]      = entry_old[slot];
                release_mask[slot] = 1'b1;
                retire_count       = retire_count + 2'd1;
                if (entry_mispredict[slot]) begin
                    // younger entries are wrong path
                    flush        = 1'b1;
                    flush_target = entry_target[slot];
                    stop         = 1'b1;
                end
            end else begin
                stop = 1'b1;
            end
        end
    end

endmodule

// ==== logic/rob_top.sv ====
`timescale 1ns/1ns

module rob_top import rob_pkg::*; #(
    parameter  int rob_depth   = 8,
    localparam int index_width = $clog2(rob_depth),
    localparam int count_width = $clog2(rob_depth + 1)
) (
    input  logic                   clock,
    input  logic                   reset,
    // dispatch, lane 0 oldest
    input  logic [lanes-1:0]       dispatch_valid,
    input  phys_tag_t              dispatch_dest [lanes],
    input  phys_tag_t              dispatch_old [lanes],
    input  arch_reg_t              dispatch_arch [lanes],
    input  logic [lanes-1:0]       dispatch_predicted_taken,
    output logic [lanes-1:0]       dispatch_accept,
    output logic [count_width-1:0] open_spots,
    // completion
    input  logic [lanes-1:0]       cdb_valid,
    input  phys_tag_t              cdb_tag [lanes],
    input  logic                   branch_valid,
    input  phys_tag_t              branch_tag,
    input  logic                   branch_taken,
    input  addr_t                  branch_target,
    // retirement
    output logic [lanes-1:0]       retire_valid,
    output arch_reg_t              retire_arch [lanes],
    output phys_tag_t              retire_dest [lanes],
    output phys_tag_t              retire_old [lanes],
    output logic                   flush,
    output addr_t                  flush_target
);

    logic [index_width-1:0] alloc_index [lanes];
    logic [index_width-1:0] head;
    logic [rob_depth-1:0]   release_mask;
    logic [1:0]             retire_count;

    phys_tag_t              entry_dest [rob_depth];
    phys_tag_t              entry_old [rob_depth];
    arch_reg_t              entry_arch [rob_depth];
    logic [rob_depth-1:0]   entry_predicted_taken;
    logic [rob_depth-1:0]   entry_valid;
    logic [rob_depth-1:0]   entry_done;
    logic [rob_depth-1:0]   entry_mispredict;
    addr_t                  entry_target [rob_depth];

    rob_control #(.rob_depth(rob_depth)) u_control (
        .clock           (clock),
        .reset           (reset),
        .dispatch_valid  (dispatch_valid),
        .retire_count    (retire_count),
        .flush           (flush),
        .dispatch_accept (dispatch_accept),
        .alloc_index     (alloc_index),
        .open_spots      (open_spots),
        .head            (head)
    );

    rob_entry_table #(.rob_depth(rob_depth)) u_entry_table (
        .clock                    (clock),
        .reset                    (reset),
        .dispatch_accept          (dispatch_accept),
        .alloc_index              (alloc_index),
        .dispatch_dest            (dispatch_dest),
        .dispatch_old             (dispatch_old),
        .dispatch_arch            (dispatch_arch),
        .dispatch_predicted_taken (dispatch_predicted_taken),
        .entry_dest               (entry_dest),
        .entry_old                (entry_old),
        .entry_arch               (entry_arch),
        .entry_predicted_taken    (entry_predicted_taken)
    );

    rob_status_table #(.rob_depth(rob_depth)) u_status_table (
        .clock                 (clock),
        .reset                 (reset),
        .flush                 (flush),
        .dispatch_accept       (dispatch_accept),
        .alloc_index           (alloc_index),
        .release_mask          (release_mask),
        .entry_dest            (entry_dest),
        .entry_predicted_taken (entry_predicted_taken),
        .cdb_valid             (cdb_valid),
        .cdb_tag               (cdb_tag),
        .branch_valid          (branch_valid),
        .branch_taken          (branch_taken),
        .branch_tag            (branch_tag),
        .branch_target         (branch_target),
        .entry_valid           (entry_valid),
        .entry_done            (entry_done),
        .entry_mispredict      (entry_mispredict),
        .entry_target          (entry_target)
    );

    rob_retire_window #(.rob_depth(rob_depth)) u_retire_window (
        .head             (head),
        .entry_valid      (entry_valid),
        .entry_done       (entry_done),
        .entry_mispredict (entry_mispredict),
        .entry_target     (entry_target),
        .entry_arch       (entry_arch),
        .entry_dest       (entry_dest),
        .entry_old        (entry_old),
        .retire_valid     (retire_valid),
        .retire_arch      (retire_arch),
        .retire_dest      (retire_dest),
        .retire_old       (retire_old),
        .release_mask     (release_mask),
        .retire_count     (retire_count),
        .flush            (flush),
        .flush_target     (flush_target)
    );

endmodule

// ==== sim/rob_tb.sv ====
`timescale 1ns/1ns

module rob_tb import rob_pkg::*; ();

    localparam int rob_depth    = 8;
    localparam int reset_cycles = 10;
    localparam int drive_delay  = 10;
    localparam int sample_delay = 70;

    // one row per clock cycle with inputs first and expected outputs after
    typedef struct packed {
        logic                    rst;
        logic [lanes-1:0]        dv;
        logic [lanes-1:0]        dtaken;
        phys_tag_t [lanes-1:0]   ddest;
        phys_tag_t [lanes-1:0]   dold;
        arch_reg_t [lanes-1:0]   darch;
        logic [lanes-1:0]        cv;
        phys_tag_t [lanes-1:0]   ctag;
        logic                    bv;
        logic                    btaken;
        phys_tag_t               btag;
        addr_t                   btarget;
        logic [lanes-1:0]        exp_accept;
        logic [3:0]              exp_spots;
        logic [lanes-1:0]        exp_retire;
        phys_tag_t [lanes-1:0]   exp_rdest;
        phys_tag_t [lanes-1:0]   exp_rold;
        arch_reg_t [lanes-1:0]   exp_rarch;
        logic                    exp_flush;
        addr_t                   exp_target;
    } row_t;

    logic             clock;
    logic             reset;
    logic [lanes-1:0] dispatch_valid;
    phys_tag_t        dispatch_dest [lanes];
    phys_tag_t        dispatch_old [lanes];
    arch_reg_t        dispatch_arch [lanes];
    logic [lanes-1:0] dispatch_predicted_taken;
    logic [lanes-1:0] dispatch_accept;
    logic [3:0]       open_spots;
    logic [lanes-1:0] cdb_valid;
    phys_tag_t        cdb_tag [lanes];
    logic             branch_valid;
    phys_tag_t        branch_tag;
    logic             branch_taken;
    addr_t            branch_target;
    logic [lanes-1:0] retire_valid;
    arch_reg_t        retire_arch [lanes];
    phys_tag_t        retire_dest [lanes];
    phys_tag_t        retire_old [lanes];
    logic             flush;
    addr_t            flush_target;

    row_t rows [$];
    row_t cur;
    int   cycle_count;

    rob_top #(.rob_depth(rob_depth)) dut (
        .clock                    (clock),
        .reset                    (reset),
        .dispatch_valid           (dispatch_valid),
        .dispatch_dest            (dispatch_dest),
        .dispatch_old             (dispatch_old),
        .dispatch_arch            (dispatch_arch),
        .dispatch_predicted_taken (dispatch_predicted_taken),
        .dispatch_accept          (dispatch_accept),
        .open_spots               (open_spots),
        .cdb_valid                (cdb_valid),
        .cdb_tag                  (cdb_tag),
        .branch_valid             (branch_valid),
        .branch_tag               (branch_tag),
        .branch_taken             (branch_taken),
        .branch_target            (branch_target),
        .retire_valid             (retire_valid),
        .retire_arch              (retire_arch),
        .retire_dest              (retire_dest),
        .retire_old               (retire_old),
        .flush                    (flush),
        .flush_target             (flush_target)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // instruction n carries its own dest, old and arch values
    function automatic phys_tag_t dest_of(input int n);
        return phys_tag_t'(16 + n);
    endfunction

    function automatic phys_tag_t old_of(input int n);
        return phys_tag_t'(40 + n);
    endfunction

    function automatic arch_reg_t arch_of(input int n);
        return arch_reg_t'(n);
    endfunction

    task automatic start_row(input int spots);
        cur           = '0;
        cur.exp_spots = 4'(spots);
    endtask

    task automatic offer_instr(input int lane, input int n, input logic taken,
                               input logic accepted);
        cur.dv[lane]         = 1'b1;
        cur.dtaken[lane]     = taken;
        cur.ddest[lane]      = dest_of(n);
        cur.dold[lane]       = old_of(n);
        cur.darch[lane]      = arch_of(n);
        cur.exp_accept[lane] = accepted;
    endtask

    task automatic complete_instr(input int lane, input int n);
        cur.cv[lane]   = 1'b1;
        cur.ctag[lane] = dest_of(n);
    endtask

    task automatic resolve_branch(input int n, input logic taken, input addr_t target);
        cur.bv      = 1'b1;
        cur.btaken  = taken;
        cur.btag    = dest_of(n);
        cur.btarget = target;
    endtask

    task automatic expect_retire(input int lane, input int n);
        cur.exp_retire[lane] = 1'b1;
        cur.exp_rdest[lane]  = dest_of(n);
        cur.exp_rold[lane]   = old_of(n);
        cur.exp_rarch[lane]  = arch_of(n);
    endtask

    task automatic expect_flush(input addr_t target);
        cur.exp_flush  = 1'b1;
        cur.exp_target = target;
    endtask

    task automatic push_row();
        rows.push_back(cur);
    endtask

    task automatic build_table();
        // idle right after reset
        start_row(8);
        push_row();
        // three-wide dispatch into an empty buffer
        start_row(8);
        offer_instr(0, 0, 0, 1);
        offer_instr(1, 1, 0, 1);
        offer_instr(2, 2, 0, 1);
        push_row();
        // I3 is a branch predicted taken
        start_row(5);
        offer_instr(0, 3, 1, 1);
        offer_instr(1, 4, 0, 1);
        offer_instr(2, 5, 0, 1);
        push_row();
        // two free slots and lane 2 dropped
        start_row(2);
        offer_instr(0, 6, 0, 1);
        offer_instr(1, 7, 0, 1);
        offer_instr(2, 8, 0, 0);
        complete_instr(0, 2);
        complete_instr(1, 1);
        push_row();
        // head completes only once the buffer is full
        start_row(0);
        offer_instr(0, 8, 0, 0);
        complete_instr(2, 0);
        push_row();
        // head run retires while I8 to I10 wrap into entries 0 to 2
        // I8 is a branch predicted not taken
        start_row(3);
        expect_retire(0, 0);
        expect_retire(1, 1);
        expect_retire(2, 2);
        offer_instr(0, 8, 0, 1);
        offer_instr(1, 9, 0, 1);
        offer_instr(2, 10, 0, 1);
        resolve_branch(3, 1, 32'h0000_0400);
        complete_instr(0, 4);
        push_row();
        // correctly predicted branch retires quietly while I5 is still pending
        start_row(2);
        expect_retire(0, 3);
        expect_retire(1, 4);
        complete_instr(0, 5);
        complete_instr(1, 6);
        complete_instr(2, 10);
        push_row();
        // I8 resolves against its prediction
        start_row(4);
        expect_retire(0, 5);
        expect_retire(1, 6);
        offer_instr(0, 11, 0, 1);
        resolve_branch(8, 1, 32'h0000_1234);
        complete_instr(0, 7);
        complete_instr(1, 9);
        push_row();
        // I7 and I8 retire across the wrap and I8 flushes
        // finished I9 and I10 stay behind and dispatch is refused
        start_row(8);
        expect_retire(0, 7);
        expect_retire(1, 8);
        expect_flush(32'h0000_1234);
        offer_instr(0, 12, 0, 0);
        offer_instr(1, 13, 0, 0);
        offer_instr(2, 14, 0, 0);
        push_row();
        start_row(8);
        offer_instr(0, 15, 0, 1);
        offer_instr(1, 16, 0, 1);
        offer_instr(2, 17, 0, 1);
        push_row();
        start_row(5);
        complete_instr(0, 15);
        complete_instr(1, 16);
        push_row();
        start_row(7);
        expect_retire(0, 15);
        expect_retire(1, 16);
        push_row();
        // mid-run reset with I17 still in flight and no checks
        cur     = '0;
        cur.rst = 1'b1;
        push_row();
        start_row(8);
        push_row();
        start_row(8);
        offer_instr(0, 18, 0, 1);
        offer_instr(1, 19, 0, 1);
        offer_instr(2, 20, 0, 1);
        push_row();
        start_row(5);
        complete_instr(0, 18);
        push_row();
        start_row(6);
        expect_retire(0, 18);
        push_row();
        start_row(6);
        push_row();
    endtask

    task automatic apply_row(input row_t r);
        reset                    = r.rst;
        dispatch_valid           = r.dv;
        dispatch_predicted_taken = r.dtaken;
        cdb_valid                = r.cv;
        branch_valid             = r.bv;
        branch_taken             = r.btaken;
        branch_tag               = r.btag;
        branch_target            = r.btarget;
        for (int k = 0; k < lanes; k++) begin
            dispatch_dest[k] = r.ddest[k];
            dispatch_old[k]  = r.dold[k];
            dispatch_arch[k] = r.darch[k];
            cdb_tag[k]       = r.ctag[k];
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s is %0h, expected %0h",
                     $time, name, actual, expected);
            $display("Checks failed");
            $fatal(1, "stopping at the first error");
        end
    endtask

    task automatic check_row(input row_t r);
        check_value("dispatch_accept", 32'(dispatch_accept), 32'(r.exp_accept));
        check_value("open_spots", 32'(open_spots), 32'(r.exp_spots));
        check_value("retire_valid", 32'(retire_valid), 32'(r.exp_retire));
        for (int k = 0; k < lanes; k++) begin
            // lane payload only means something on a retiring lane
            if (r.exp_retire[k]) begin
                check_value($sformatf("retire_dest[%0d]", k), 32'(retire_dest[k]),
                            32'(r.exp_rdest[k]));
                check_value($sformatf("retire_old[%0d]", k), 32'(retire_old[k]),
                            32'(r.exp_rold[k]));
                check_value($sformatf("retire_arch[%0d]", k), 32'(retire_arch[k]),
                            32'(r.exp_rarch[k]));
            end
        end
        check_value("flush", 32'(flush), 32'(r.exp_flush));
        if (r.exp_flush) begin
            check_value("flush_target", flush_target, r.exp_target);
        end
    endtask

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clock);
            cycle_count++;
            if (cycle_count > reset_cycles + rows.size() + 20) begin
                $display("Timeout after %0d cycles, the stimulus table never finished",
                         cycle_count);
                $display("Checks failed");
                $fatal(1, "run stopped by timeout");
            end
        end
    end

    initial begin
        cur = '0;
        apply_row(cur);
        reset = 1'b1;
        build_table();
        repeat (reset_cycles) @(posedge clock);
        for (int i = 0; i < rows.size(); i++) begin
            #drive_delay;
            apply_row(rows[i]);
            #sample_delay;
            if (!rows[i].rst) begin
                check_row(rows[i]);
            end
            @(posedge clock);
        end
        $display("All checks passed");
        $finish;
    end

endmodule

// ==== vlog.f ====
logic/rob_pkg.sv
logic/rob_control.sv
logic/rob_entry_table.sv
logic/rob_status_table.sv
logic/rob_retire_window.sv
logic/rob_top.sv
sim/rob_tb.sv

// ==== Bender.yml ====
package:
  name: rob

sources:
  - files:
      - logic/rob_pkg.sv
      - logic/rob_control.sv
      - logic/rob_entry_table.sv
      - logic/rob_status_table.sv
      - logic/rob_retire_window.sv
      - logic/rob_top.sv
  - target: simulation
    files:
      - sim/rob_tb.sv
